/* Makefile */
TOOL       := verilator
TOP        := shift_unit_tb
FILELIST   := project.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/shift_model.svh */
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

// Expected operand 2 and shifter carry for one request
function automatic shift_pkg::shift_res_t shift_ref(input shift_pkg::shift_req_t req);
  shift_pkg::shift_res_t res;
  logic [31:0]           d;
  int                    n;
  int                    m;
  d = req.data;
  n = int'(req.amount);
  m = n % 32;                           // Rotate distance
  res.data      = d;                    // Pass through with old C by default
  res.carry_out = req.carry_in;
  if (req.imm_zero) begin
    case (req.func)
      shift_pkg::LSL: res.data = d;     // LSL #0
      shift_pkg::LSR: begin             // LSR #32
        res.data      = '0;
        res.carry_out = d[31];
      end
      shift_pkg::ASR: begin             // ASR #32
        res.data      = {32{d[31]}};
        res.carry_out = d[31];
      end
      default: begin                    // RRX
        res.data      = {req.carry_in, d[31:1]};
        res.carry_out = d[0];
      end
    endcase
  end else if (n != 0) begin
    case (req.func)
      shift_pkg::LSL: begin
        res.data      = (n < 32) ? (d << n) : '0;
        res.carry_out = (n < 32) ? d[32-n] : ((n == 32) ? d[0] : 1'b0);
      end
      shift_pkg::LSR: begin
        res.data      = (n < 32) ? (d >> n) : '0;
        res.carry_out = (n < 32) ? d[n-1] : ((n == 32) ? d[31] : 1'b0);
      end
      shift_pkg::ASR: begin
        res.data      = (n < 32) ? 32'($signed(d) >>> n) : {32{d[31]}};
        res.carry_out = (n < 32) ? d[n-1] : d[31];
      end
      default: begin
        // Multiple of 32 leaves the word and takes C from bit 31
        res.data      = (m == 0) ? d : ((d >> m) | (d << (32 - m)));
        res.carry_out = (m == 0) ? d[31] : d[m-1];
      end
    endcase
  end
  return res;
endfunction

`endif

/* dv/shift_unit_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module shift_unit_tb;

  `include "shift_model.svh"

  localparam int CLK_PERIOD = 8;
  localparam int WAIT_LIMIT = 100;    // Cycles per wait loop

  logic                  clk;
  logic                  rst_n;
  logic                  valid;
  shift_pkg::shift_req_t req;
  logic                  o_valid;
  logic                  o_busy;
  shift_pkg::shift_res_t o_res;

  shift_pkg::shift_res_t exp_q[$];    // Scoreboard in issue order
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  int out_cnt   = 0;                  // o_valid pulses seen
  int test_base = 0;

  shift_unit_top i_dut (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_valid (valid),
    .i_req   (req),
    .o_valid (o_valid),
    .o_res   (o_res),
    .o_busy  (o_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) pass_cnt++;
    else begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      fail_cnt++;
    end
  endtask

  function automatic shift_pkg::shift_req_t make_req(input logic [31:0] data,
      input logic cin, input logic [7:0] amt, input logic iz, input int f);
    shift_pkg::shift_req_t r;
    r.data     = data;
    r.carry_in = cin;
    r.amount   = amt;
    r.imm_zero = iz;
    r.func     = shift_pkg::shift_func_e'(f[1:0]);
    return r;
  endfunction

  task automatic wait_not_busy();
    int cnt;
    cnt = 0;
    while (o_busy && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (o_busy) begin
      $display("Timeout, o_busy never fell");
      fail_cnt++;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout, %0d results never came out", exp_q.size());
      fail_cnt++;
      exp_q.delete();
    end
  endtask

  // Drive one strobe starting 1 ns after an edge
  task automatic issue_req(input shift_pkg::shift_req_t r);
    wait_not_busy();
    valid = 1'b1;
    req   = r;
    exp_q.push_back(shift_ref(r));
    @(posedge clk);
    #1;
    valid = 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %-10s %0d errors", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  // Compare on the falling edge where outputs are settled
  always @(negedge clk) begin : compare_results
    shift_pkg::shift_res_t exp;
    if (rst_n && o_valid) begin
      out_cnt++;
      assert (exp_q.size() > 0) pass_cnt++;
      else begin
        $display("Result came out with nothing expected");
        fail_cnt++;
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        check_value("o_res.data", o_res.data, exp.data);
        check_value("o_res.carry_out", 32'(o_res.carry_out), 32'(exp.carry_out));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int          amts[6];
    logic [31:0] rnd;
    int          base;
    amts = '{4, 31, 32, 33, 64, 255};
    void'($urandom(33));
    rst_n = 1'b0;
    valid = 1'b0;
    req   = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Back to back quick amounts with o_busy low
    for (int f = 0; f < 4; f++) begin
      for (int a = 0; a < 4; a++) begin
        repeat (4) begin
          rnd = $urandom();
          issue_req(make_req($urandom(), rnd[0], 8'(a), 1'b0, f));
          check_value("o_busy", 32'(o_busy), 32'd0);
        end
      end
    end
    wait_drain();
    report_test("quick");

    // LSL #0, LSR #32, ASR #32, RRX
    for (int f = 0; f < 4; f++) begin
      for (int c = 0; c < 2; c++) begin
        for (int b = 0; b < 2; b++) begin
          rnd = $urandom();
          issue_req(make_req({b[0], rnd[30:0]}, c[0], 8'd0, 1'b1, f));
        end
      end
    end
    wait_drain();
    report_test("imm_zero");

    for (int f = 0; f < 4; f++) begin
      foreach (amts[i]) begin
        rnd = $urandom();
        issue_req(make_req(rnd | 32'h8000_0000, rnd[4], 8'(amts[i]), 1'b0, f));
        issue_req(make_req(rnd & 32'h7fff_ffff, rnd[5], 8'(amts[i]), 1'b0, f));
      end
    end
    wait_drain();
    report_test("full");

    // Exact cycle counts for quick then full
    valid = 1'b1;
    req   = make_req($urandom(), 1'b1, 8'd2, 1'b0, 1);
    exp_q.push_back(shift_ref(req));
    @(posedge clk);
    #1;
    valid = 1'b0;
    check_value("o_valid", 32'(o_valid), 32'd1);
    check_value("o_busy", 32'(o_busy), 32'd0);
    @(posedge clk);
    #1;
    check_value("o_valid", 32'(o_valid), 32'd0);
    valid = 1'b1;
    req   = make_req($urandom(), 1'b0, 8'd17, 1'b0, 2);
    exp_q.push_back(shift_ref(req));
    @(posedge clk);
    #1;
    valid = 1'b0;
    check_value("o_busy", 32'(o_busy), 32'd1);    // Stall cycle
    check_value("o_valid", 32'(o_valid), 32'd0);
    @(posedge clk);
    #1;
    check_value("o_busy", 32'(o_busy), 32'd0);
    check_value("o_valid", 32'(o_valid), 32'd1);  // Two cycles after issue
    wait_drain();
    report_test("timing");

    base = out_cnt;
    repeat (500) begin
      rnd = $urandom();
      issue_req(make_req($urandom(), rnd[3], rnd[0] ? 8'(rnd[9:8]) : rnd[23:16],
                         rnd[0] & rnd[1] & rnd[2], int'(rnd[5:4])));
    end
    wait_drain();
    check_value("o_valid count", 32'(out_cnt - base), 32'd500);
    report_test("random");

    // Reset lands while the full shifter is in flight
    issue_req(make_req($urandom(), 1'b1, 8'd45, 1'b0, 3));
    check_value("o_busy", 32'(o_busy), 32'd1);
    rst_n = 1'b0;
    exp_q.delete();
    @(posedge clk);
    #1;
    check_value("o_valid", 32'(o_valid), 32'd0);
    check_value("o_busy", 32'(o_busy), 32'd0);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    issue_req(make_req($urandom(), 1'b0, 8'd40, 1'b0, 0));
    issue_req(make_req($urandom(), 1'b1, 8'd3, 1'b0, 2));
    wait_drain();
    report_test("reset");

    $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
+incdir+dv
src/shift_pkg.sv
src/shifter_quick.sv
src/shifter_full.sv
src/shift_ctrl.sv
src/shift_unit_top.sv
dv/shift_unit_tb.sv

/* src/shift_consts.svh */
`ifndef SHIFT_CONSTS_SVH
`define SHIFT_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Operand width, the shift rules assume 32
`define SHIFT_DATA_W 32

// Low byte of Rs, or a 5 bit immediate zero extended
`define SHIFT_AMT_W 8

// Largest register amount the quick shifter gets right
`define SHIFT_QUICK_MAX 3

`endif

/* src/shift_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "shift_consts.svh"

module shift_ctrl (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_valid,
  input  var shift_pkg::shift_req_t i_req,
  input  var shift_pkg::shift_res_t i_quick_res,
  input  var shift_pkg::shift_res_t i_full_res,
  output var shift_pkg::shift_req_t o_path_req,   // To both shifters
  output var logic                  o_full_start,
  output var logic                  o_valid,
  output var shift_pkg::shift_res_t o_res,
  output var logic                  o_busy
);

  shift_pkg::ctrl_state_e state_q;
  logic                   quick_sel;
  logic                   valid_q;
  logic                   busy_q;
  logic                   full_sel_q;   // Present full shifter output
  shift_pkg::shift_res_t  quick_res_q;

  ////////////////////////////////////////////////////////////////////////////
  // Path select
  ////////////////////////////////////////////////////////////////////////////

  assign quick_sel = i_req.imm_zero ||
                     (i_req.amount <= shift_pkg::shift_amt_t'(`SHIFT_QUICK_MAX));

  assign o_path_req   = i_req;
  assign o_full_start = i_valid && !quick_sel;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q    <= shift_pkg::IDLE_ISSUE;
      busy_q     <= 1'b0;
      valid_q    <= 1'b0;
      full_sel_q <= 1'b0;
    end else begin
      unique case (state_q)
        shift_pkg::IDLE_ISSUE: begin
          valid_q    <= i_valid && quick_sel;   // Quick, done next cycle
          full_sel_q <= 1'b0;
          if (o_full_start) begin
            state_q <= shift_pkg::FULL_WAIT;
            busy_q  <= 1'b1;
          end
        end
        default: begin
          state_q    <= shift_pkg::IDLE_ISSUE;  // Full result lands now
          busy_q     <= 1'b0;
          valid_q    <= 1'b1;
          full_sel_q <= 1'b1;
        end
      endcase
    end
  end

  // Result payload
  always_ff @(posedge i_clk) begin
    if (i_valid && quick_sel) quick_res_q <= i_quick_res;
  end

  assign o_res   = full_sel_q ? i_full_res : quick_res_q;
  assign o_valid = valid_q;
  assign o_busy  = busy_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_no_issue_busy: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) o_busy |-> !i_valid
  );

  a_full_result: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      o_full_start |-> ##2 (o_valid && (o_res == i_full_res))
  );

  a_busy_state: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) o_busy |-> (state_q == shift_pkg::FULL_WAIT)
  );

endmodule

`default_nettype wire

/* src/shift_pkg.sv */
`default_nettype none

`include "shift_consts.svh"

package shift_pkg;

  typedef logic [`SHIFT_DATA_W-1:0] shift_data_t; // Operand / result word
  typedef logic [`SHIFT_AMT_W-1:0]  shift_amt_t;  // Shift amount

  // Same encoding as the instruction shift field
  typedef enum logic [1:0] {
    LSL = 2'd0,
    LSR = 2'd1,
    ASR = 2'd2,
    ROR = 2'd3  // RRX when imm_zero set
  } shift_func_e;

  typedef struct packed {
    shift_data_t data;
    logic        carry_in;   // Old C flag
    shift_amt_t  amount;
    logic        imm_zero;   // Immediate amount of zero selected
    shift_func_e func;
  } shift_req_t;

  typedef struct packed {
    shift_data_t data;
    logic        carry_out;
  } shift_res_t;

  typedef enum logic {
    IDLE_ISSUE = 1'b0,
    FULL_WAIT  = 1'b1   // Full shifter in flight, issue stalled
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/shift_unit_top.sv */
`default_nettype none
`timescale 1ns/1ps

// Operand 2 barrel shifter, quick and full paths
module shift_unit_top (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_valid,   // One cycle strobe
  input  var shift_pkg::shift_req_t i_req,
  output var logic                  o_valid,   // One cycle pulse
  output var shift_pkg::shift_res_t o_res,
  output var logic                  o_busy     // Hold i_valid low while set
);

  shift_pkg::shift_req_t path_req;
  shift_pkg::shift_res_t quick_res;
  shift_pkg::shift_res_t full_res;
  logic                  full_start;

  shift_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_req        (i_req),
    .i_quick_res  (quick_res),
    .i_full_res   (full_res),
    .o_path_req   (path_req),
    .o_full_start (full_start),
    .o_valid      (o_valid),
    .o_res        (o_res),
    .o_busy       (o_busy)
  );

  // Combinational, registered in the controller
  shifter_quick u_quick (
    .i_req (path_req),
    .o_res (quick_res)
  );

  shifter_full u_full (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_start (full_start),
    .i_req   (path_req),
    .o_res   (full_res)
  );

endmodule

`default_nettype wire

/* src/shifter_full.sv */
`default_nettype none
`timescale 1ns/1ps

`include "shift_consts.svh"

// Two stage shifter, any amount 0..255
// Immediate-zero forms never come here, they always go quick
module shifter_full (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_start,   // Request valid this cycle
  input  var shift_pkg::shift_req_t i_req,
  output var shift_pkg::shift_res_t o_res     // Two cycles after i_start
);

  typedef struct packed {
    shift_pkg::shift_data_t data;   // Bit reversed for LSL
    logic                   carry;
    shift_pkg::shift_func_e func;
    logic                   zero;   // Amount == 0
    logic                   eq32;   // Amount == 32
    logic                   gt32;   // Amount > 32
    logic [4:0]             mod;    // Amount mod 32
  } stage1_t;

  stage1_t                s1_q;
  logic                   s1_vld_q;
  shift_pkg::shift_data_t fill_w;   // Sign fill for ASR
  shift_pkg::shift_data_t sh_d;
  logic                   sh_c;
  shift_pkg::shift_res_t  s2_d;
  shift_pkg::shift_res_t  s2_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1, operand and amount decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= i_start;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      // LSL runs on the right shifter with the word mirrored
      s1_q.data  <= (i_req.func == shift_pkg::LSL) ? {<<{i_req.data}} : i_req.data;
      s1_q.carry <= i_req.carry_in;
      s1_q.func  <= i_req.func;
      s1_q.zero  <= (i_req.amount == '0);
      s1_q.eq32  <= (i_req.amount == shift_pkg::shift_amt_t'(32));
      s1_q.gt32  <= (i_req.amount >  shift_pkg::shift_amt_t'(32));
      s1_q.mod   <= i_req.amount[4:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2, log shifter plus range fixups
  ////////////////////////////////////////////////////////////////////////////

  assign fill_w = {`SHIFT_DATA_W{(s1_q.func == shift_pkg::ASR) && s1_q.data[31]}};

  // Five levels, 1/2/4/8/16, all shifting right
  always_comb begin
    sh_d = s1_q.data;
    sh_c = s1_q.carry;
    for (int lvl = 0; lvl < 5; lvl++) begin
      if (s1_q.mod[lvl]) begin
        sh_c = sh_d[(1 << lvl) - 1];   // Last bit out
        if (s1_q.func == shift_pkg::ROR) begin
          sh_d = (sh_d >> (1 << lvl)) | (sh_d << (`SHIFT_DATA_W - (1 << lvl)));
        end else begin
          sh_d = (sh_d >> (1 << lvl)) | (fill_w << (`SHIFT_DATA_W - (1 << lvl)));
        end
      end
    end
  end

  always_comb begin
    s2_d.data      = sh_d;
    s2_d.carry_out = sh_c;
    if (s1_q.zero) begin
      s2_d.data      = s1_q.data;          // Pass through, old C
      s2_d.carry_out = s1_q.carry;
    end else begin
      unique case (s1_q.func)
        shift_pkg::LSL, shift_pkg::LSR: begin
          if (s1_q.eq32) begin
            s2_d.data      = '0;
            s2_d.carry_out = s1_q.data[31]; // Bit 0 of Rm for LSL, mirrored
          end else if (s1_q.gt32) begin
            s2_d.data      = '0;
            s2_d.carry_out = 1'b0;
          end
        end
        shift_pkg::ASR: begin
          if (s1_q.eq32 || s1_q.gt32) begin
            s2_d.data      = fill_w;
            s2_d.carry_out = s1_q.data[31];
          end
        end
        default: begin
          // ROR by a nonzero multiple of 32
          if (s1_q.mod == '0) begin
            s2_d.data      = s1_q.data;
            s2_d.carry_out = s1_q.data[31];
          end
        end
      endcase
    end
    if (s1_q.func == shift_pkg::LSL) s2_d.data = {<<{s2_d.data}}; // Undo mirror
  end

  always_ff @(posedge i_clk) begin
    if (s1_vld_q) s2_q <= s2_d;
  end

  assign o_res = s2_q;

  // Issue stalls one cycle after a full start
  a_no_back_to_back: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_start |=> !i_start
  );

endmodule

`default_nettype wire

/* src/shifter_quick.sv */
`default_nettype none
`timescale 1ns/1ps

`include "shift_consts.svh"

// Single level shifter, only correct for amounts 0..3 and the imm-zero forms
module shifter_quick (
  input  var shift_pkg::shift_req_t i_req,
  output var shift_pkg::shift_res_t o_res
);

  shift_pkg::shift_data_t din;
  logic                   cin;
  logic [1:0]             amt;    // Only low bits matter here

  // MSB is carry out
  logic [`SHIFT_DATA_W:0] lsl_cd;
  logic [`SHIFT_DATA_W:0] lsr_cd;
  logic [`SHIFT_DATA_W:0] asr_cd;
  logic [`SHIFT_DATA_W:0] ror_cd;
  logic [`SHIFT_DATA_W:0] sel_cd;

  assign din = i_req.data;
  assign cin = i_req.carry_in;
  assign amt = i_req.amount[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Candidate results
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // LSL #0 keeps the operand and the old C flag
    unique case (amt)
      2'd0:    lsl_cd = {cin, din};
      2'd1:    lsl_cd = {din[31], din[30:0], 1'b0};
      2'd2:    lsl_cd = {din[30], din[29:0], 2'b0};
      default: lsl_cd = {din[29], din[28:0], 3'b0};
    endcase
    if (i_req.imm_zero) lsl_cd = {cin, din};

    unique case (amt)
      2'd0:    lsr_cd = {cin, din};             // Fall through
      2'd1:    lsr_cd = {din[0], 1'b0, din[31:1]};
      2'd2:    lsr_cd = {din[1], 2'b0, din[31:2]};
      default: lsr_cd = {din[2], 3'b0, din[31:3]};
    endcase
    if (i_req.imm_zero) lsr_cd = {din[31], {`SHIFT_DATA_W{1'b0}}}; // LSR #32

    unique case (amt)
      2'd0:    asr_cd = {cin, din};
      2'd1:    asr_cd = {din[0], {2{din[31]}}, din[30:1]};
      2'd2:    asr_cd = {din[1], {3{din[31]}}, din[30:2]};
      default: asr_cd = {din[2], {4{din[31]}}, din[30:3]};
    endcase
    if (i_req.imm_zero) asr_cd = {din[31], {`SHIFT_DATA_W{din[31]}}}; // ASR #32, sign fill

    unique case (amt)
      2'd0:    ror_cd = {cin, din};
      2'd1:    ror_cd = {din[0], din[0], din[31:1]};
      2'd2:    ror_cd = {din[1], din[1:0], din[31:2]};
      default: ror_cd = {din[2], din[2:0], din[31:3]};
    endcase
    // RRX, old carry rotates into bit 31
    if (i_req.imm_zero) ror_cd = {din[0], cin, din[31:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Function select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (i_req.func)
      shift_pkg::LSL: sel_cd = lsl_cd;
      shift_pkg::LSR: sel_cd = lsr_cd;
      shift_pkg::ASR: sel_cd = asr_cd;
      default:        sel_cd = ror_cd;
    endcase
  end

  assign o_res.carry_out = sel_cd[`SHIFT_DATA_W];
  assign o_res.data      = sel_cd[`SHIFT_DATA_W-1:0];

endmodule

`default_nettype wire
